// ==== verilog/mode_pkg.sv ====
package mode_pkg;

	// ========================================
	// Sample geometry
	// ========================================

	localparam int sample_w = 4;
	localparam int num_samples = 5;
	localparam int num_values = 1 << sample_w; // One flag per possible value.

	typedef logic [sample_w-1:0] sample_t;

	// s0 sits in the low nibble, matching the bus write word.
	typedef struct packed {
		sample_t s4;
		sample_t s3;
		sample_t s2;
		sample_t s1;
		sample_t s0;
	} sample_set_t;

	// Count class of one value within a set.
	typedef enum logic [1:0] {
		none = 2'd0,
		once = 2'd1,
		twice = 2'd2,
		thrice = 2'd3 // Three or more.
	} count_class_t;

	typedef struct packed {
		count_class_t cls;
		sample_t mode;
	} mode_result_t;

	// ========================================
	// Bus map
	// ========================================

	localparam int wb_data_w = 32;
	localparam int wb_adr_w = 4;

	localparam logic [wb_adr_w-1:0] adr_samples = wb_adr_w'(0);
	localparam logic [wb_adr_w-1:0] adr_result = wb_adr_w'(1);

	// Layout of the result read word.
	localparam int rd_valid_bit = 8;
	localparam int rd_class_lsb = 4;
	localparam int rd_mode_lsb = 0;

	// ========================================
	// Buffering
	// ========================================

	localparam int set_fifo_depth = 8;
	localparam int result_fifo_depth = 8;

endpackage

// ==== verilog/stream_fifo.sv ====
module stream_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int depth = 8
) (
	input  logic clk,
	input  logic rst_n,

	input  payload_t in_data,
	input  logic in_valid,
	output logic in_ready,

	output payload_t out_data,
	output logic out_valid,
	input  logic out_ready
);

	typedef logic [$clog2(depth)-1:0] ptr_t;
	typedef logic [$clog2(depth):0] cnt_t;

	payload_t mem [depth];

	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t count;

	logic push;
	logic pop;

	assign in_ready = (count != cnt_t'(depth));
	assign out_valid = (count != '0);
	assign out_data = mem[rd_ptr]; // Head entry is shown as soon as it lands.

	assign push = in_valid & in_ready;
	assign pop = out_valid & out_ready;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				if (wr_ptr == ptr_t'(depth - 1)) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (pop) begin
				if (rd_ptr == ptr_t'(depth - 1)) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
			// Push and pop in one cycle leave the count alone.
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== verilog/host_port.sv ====
module host_port (
	input  logic clk,
	input  logic rst_n,

	// Wishbone classic slave.
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [mode_pkg::wb_adr_w-1:0] wb_adr,
	input  logic [mode_pkg::wb_data_w-1:0] wb_dat_w,
	output logic [mode_pkg::wb_data_w-1:0] wb_dat_r,
	output logic wb_ack,

	// Push side of the set FIFO.
	output mode_pkg::sample_set_t set_data,
	output logic set_valid,
	input  logic set_ready,

	// Pop side of the result FIFO.
	input  mode_pkg::mode_result_t res_data,
	input  logic res_valid,
	output logic res_ready
);

	logic req;
	logic hit_samples;
	logic hit_result;
	logic ack_next;
	logic [mode_pkg::wb_data_w-1:0] rd_word;

	// ========================================
	// Request decode
	// ========================================

	// A request is live until its ack goes out.
	assign req = wb_cyc & wb_stb & ~wb_ack;

	assign hit_samples = (wb_adr == mode_pkg::adr_samples);
	assign hit_result = (wb_adr == mode_pkg::adr_result);

	// Sample writes wait for room in the set FIFO and everything else acks at once.
	assign ack_next = req & (~(wb_we & hit_samples) | set_ready);

	// ========================================
	// Streams
	// ========================================

	assign set_data = mode_pkg::sample_set_t'(wb_dat_w[$bits(mode_pkg::sample_set_t)-1:0]);
	assign set_valid = req & wb_we & hit_samples; // Transfers in the cycle before ack.

	assign res_ready = req & ~wb_we & hit_result; // One pop per result read.

	always_comb begin
		rd_word = '0;
		if (res_ready && res_valid) begin
			rd_word[mode_pkg::rd_valid_bit] = 1'b1;
			rd_word[mode_pkg::rd_class_lsb +: $bits(mode_pkg::count_class_t)] = res_data.cls;
			rd_word[mode_pkg::rd_mode_lsb +: mode_pkg::sample_w] = res_data.mode;
		end
	end

	// ========================================
	// Ack and read data
	// ========================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= ack_next;
		end
	end

	// Read data is captured with the ack and is only meaningful while ack is high.
	always_ff @(posedge clk) begin
		if (ack_next) begin
			wb_dat_r <= rd_word;
		end
	end

endmodule

// ==== verilog/mode_engine.sv ====
module mode_engine (
	input  logic clk,
	input  logic rst_n,

	input  mode_pkg::sample_set_t in_data,
	input  logic in_valid,
	output logic in_ready,

	output mode_pkg::mode_result_t out_data,
	output logic out_valid,
	input  logic out_ready
);

	typedef logic [$clog2(mode_pkg::num_samples + 1)-1:0] hits_t;

	mode_pkg::sample_t samples [mode_pkg::num_samples];
	logic [mode_pkg::num_values-1:0] hot [mode_pkg::num_samples];
	mode_pkg::count_class_t [mode_pkg::num_values-1:0] cls_next;

	logic s1_valid;
	mode_pkg::count_class_t [mode_pkg::num_values-1:0] s1_cls;

	logic thrice_hit;
	logic twice_hit;
	mode_pkg::sample_t thrice_val;
	mode_pkg::sample_t twice_val;
	mode_pkg::sample_t once_val;
	mode_pkg::mode_result_t sel;

	logic s2_valid;
	mode_pkg::mode_result_t s2_result;

	logic s1_en;
	logic s2_en;

	function automatic mode_pkg::count_class_t classify(input hits_t hits);
		case (hits)
			hits_t'(0): return mode_pkg::none;
			hits_t'(1): return mode_pkg::once;
			hits_t'(2): return mode_pkg::twice;
			default: return mode_pkg::thrice;
		endcase
	endfunction

	// ========================================
	// Stage 1: one-hot decode and count
	// ========================================

	assign samples[0] = in_data.s0;
	assign samples[1] = in_data.s1;
	assign samples[2] = in_data.s2;
	assign samples[3] = in_data.s3;
	assign samples[4] = in_data.s4;

	always_comb begin
		for (int i = 0; i < mode_pkg::num_samples; i++) begin
			hot[i] = '0;
			hot[i][samples[i]] = 1'b1;
		end
	end

	// Each value counts how many of the samples landed on it.
	always_comb begin
		hits_t hits;
		for (int v = 0; v < mode_pkg::num_values; v++) begin
			hits = '0;
			for (int i = 0; i < mode_pkg::num_samples; i++) begin
				hits = hits + hits_t'(hot[i][v]);
			end
			cls_next[v] = classify(hits);
		end
	end

	// ========================================
	// Stage 2: tiered priority select
	// ========================================

	// The scan ascends, so the last hit in each tier is the largest value.
	always_comb begin
		thrice_hit = 1'b0;
		twice_hit = 1'b0;
		thrice_val = '0;
		twice_val = '0;
		once_val = '0;
		for (int v = 0; v < mode_pkg::num_values; v++) begin
			case (s1_cls[v])
				mode_pkg::thrice: begin
					thrice_hit = 1'b1;
					thrice_val = mode_pkg::sample_t'(v);
				end
				mode_pkg::twice: begin
					twice_hit = 1'b1;
					twice_val = mode_pkg::sample_t'(v);
				end
				mode_pkg::once: once_val = mode_pkg::sample_t'(v);
				default: ;
			endcase
		end
	end

	always_comb begin
		if (thrice_hit) begin
			sel = '{cls: mode_pkg::thrice, mode: thrice_val};
		end else if (twice_hit) begin
			sel = '{cls: mode_pkg::twice, mode: twice_val};
		end else begin
			sel = '{cls: mode_pkg::once, mode: once_val}; // All distinct here.
		end
	end

	// ========================================
	// Stage control
	// ========================================

	// A stage loads when the one after it is empty or draining.
	assign s2_en = ~s2_valid | out_ready;
	assign s1_en = ~s1_valid | s2_en;
	assign in_ready = s1_en;

	assign out_valid = s2_valid;
	assign out_data = s2_result;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			if (s1_en) s1_valid <= in_valid;
			if (s2_en) s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_en && in_valid) begin
			s1_cls <= cls_next;
		end
		if (s2_en && s1_valid) begin
			s2_result <= sel;
		end
	end

endmodule

// ==== verilog/mode_max_top.sv ====
module mode_max_top (
	input  logic clk,
	input  logic rst_n,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [mode_pkg::wb_adr_w-1:0] wb_adr,
	input  logic [mode_pkg::wb_data_w-1:0] wb_dat_w,
	output logic [mode_pkg::wb_data_w-1:0] wb_dat_r,
	output logic wb_ack
);

	// Bus port to set FIFO.
	mode_pkg::sample_set_t set_in_data;
	logic set_in_valid;
	logic set_in_ready;

	// Set FIFO to engine.
	mode_pkg::sample_set_t set_out_data;
	logic set_out_valid;
	logic set_out_ready;

	// Engine to result FIFO.
	mode_pkg::mode_result_t res_in_data;
	logic res_in_valid;
	logic res_in_ready;

	// Result FIFO to bus port.
	mode_pkg::mode_result_t res_out_data;
	logic res_out_valid;
	logic res_out_ready;

	host_port host_port_inst (
		.clk(clk),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.set_data(set_in_data),
		.set_valid(set_in_valid),
		.set_ready(set_in_ready),
		.res_data(res_out_data),
		.res_valid(res_out_valid),
		.res_ready(res_out_ready)
	);

	stream_fifo #(
		.payload_t(mode_pkg::sample_set_t),
		.depth(mode_pkg::set_fifo_depth)
	) set_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(set_in_data),
		.in_valid(set_in_valid),
		.in_ready(set_in_ready),
		.out_data(set_out_data),
		.out_valid(set_out_valid),
		.out_ready(set_out_ready)
	);

	mode_engine mode_engine_inst (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(set_out_data),
		.in_valid(set_out_valid),
		.in_ready(set_out_ready),
		.out_data(res_in_data),
		.out_valid(res_in_valid),
		.out_ready(res_in_ready)
	);

	stream_fifo #(
		.payload_t(mode_pkg::mode_result_t),
		.depth(mode_pkg::result_fifo_depth)
	) result_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(res_in_data),
		.in_valid(res_in_valid),
		.in_ready(res_in_ready),
		.out_data(res_out_data),
		.out_valid(res_out_valid),
		.out_ready(res_out_ready)
	);

endmodule

// ==== tb/tb_clock.sv ====
module tb_clock #(
	parameter int period = 40
) (
	output logic clk
);

	// The clock starts low so the first edge is a rising one.
	initial begin
		clk = 1'b0;
		forever begin
			#(period / 2);
			clk = ~clk;
		end
	end

endmodule

// ==== tb/mode_checker.sv ====
module mode_checker (
	input  logic clk,
	input  logic rst_n,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [mode_pkg::wb_adr_w-1:0] wb_adr,
	input  logic [mode_pkg::wb_data_w-1:0] wb_dat_w,
	input  logic [mode_pkg::wb_data_w-1:0] wb_dat_r,
	input  logic wb_ack,
	output int mismatch_count,
	output int orphan_count,
	output int results_seen,
	output int pending_sets
);

	mode_pkg::sample_set_t pending [$];

	logic cap_we;
	logic [mode_pkg::wb_adr_w-1:0] cap_adr;
	logic [mode_pkg::wb_data_w-1:0] cap_dat;

	int mismatches = 0;
	int orphans = 0;
	int seen = 0;
	int queued = 0;

	mode_pkg::sample_set_t head;
	logic [mode_pkg::wb_data_w-1:0] exp_word;

	assign mismatch_count = mismatches;
	assign orphan_count = orphans;
	assign results_seen = seen;
	assign pending_sets = queued;

	// ========================================
	// Reference model
	// ========================================

	// Three or more wins outright, then the largest pair, then the largest sample.
	function automatic logic [mode_pkg::wb_data_w-1:0] expected_word(
		input mode_pkg::sample_set_t set
	);
		logic [mode_pkg::sample_w-1:0] smp [mode_pkg::num_samples];
		logic [mode_pkg::wb_data_w-1:0] word;
		int cnt;
		int best3;
		int best2;
		int best1;
		smp[0] = set.s0;
		smp[1] = set.s1;
		smp[2] = set.s2;
		smp[3] = set.s3;
		smp[4] = set.s4;
		best3 = -1;
		best2 = -1;
		best1 = -1;
		for (int i = 0; i < mode_pkg::num_samples; i++) begin
			cnt = 0;
			for (int j = 0; j < mode_pkg::num_samples; j++) begin
				if (smp[j] == smp[i]) cnt++;
			end
			if (cnt >= 3) best3 = int'(smp[i]);
			if (cnt == 2 && int'(smp[i]) > best2) best2 = int'(smp[i]);
			if (int'(smp[i]) > best1) best1 = int'(smp[i]);
		end
		word = '0;
		word[mode_pkg::rd_valid_bit] = 1'b1;
		if (best3 >= 0) begin
			word[mode_pkg::rd_class_lsb +: 2] = 2'd3;
			word[mode_pkg::rd_mode_lsb +: mode_pkg::sample_w] = 4'(best3);
		end else if (best2 >= 0) begin
			word[mode_pkg::rd_class_lsb +: 2] = 2'd2;
			word[mode_pkg::rd_mode_lsb +: mode_pkg::sample_w] = 4'(best2);
		end else begin
			word[mode_pkg::rd_class_lsb +: 2] = 2'd1;
			word[mode_pkg::rd_mode_lsb +: mode_pkg::sample_w] = 4'(best1);
		end
		return word;
	endfunction

	// ========================================
	// Bus monitor
	// ========================================

	// The request is held until ack, so the copy taken here belongs to the ack that follows.
	always @(posedge clk) begin
		cap_we <= wb_we & wb_cyc & wb_stb;
		cap_adr <= wb_adr;
		cap_dat <= wb_dat_w;
	end

	always @(negedge clk) begin
		if (rst_n && wb_ack) begin
			if (cap_we && cap_adr == mode_pkg::adr_samples) begin
				pending.push_back(
					mode_pkg::sample_set_t'(cap_dat[$bits(mode_pkg::sample_set_t)-1:0]));
			end else if (!cap_we && cap_adr == mode_pkg::adr_result &&
					wb_dat_r[mode_pkg::rd_valid_bit]) begin
				if (pending.size() == 0) begin
					orphans++;
					$display("Time %0t: a valid result was read with no sample set pending",
						$time);
				end else begin
					head = pending.pop_front();
					exp_word = expected_word(head);
					seen++;
					if (wb_dat_r !== exp_word) begin
						mismatches++;
						$display("** Error at time %0t: set %h expected %h, got %h",
							$time, head, exp_word, wb_dat_r);
					end
				end
			end else if (!cap_we && wb_dat_r !== '0) begin
				mismatches++; // Empty result reads and unmapped reads return zero.
				$display("** Error at time %0t: read at address %0d expected %h, got %h",
					$time, cap_adr, 32'h0, wb_dat_r);
			end
			queued = pending.size();
		end
	end

endmodule

// ==== tb/mode_max_tb.sv ====
module mode_max_tb;

	localparam int clk_period = 40;
	localparam int reset_cycles = 16;
	localparam int random_sets = 300;
	localparam int directed_sets = 10;
	localparam int fill_sets = 19;
	localparam int total_sets = random_sets + directed_sets + fill_sets;
	localparam int set_cycle_bound = 24; // A write, a read and some waiting.
	localparam int margin_cycles = 500;
	localparam int watchdog_cycles = total_sets * set_cycle_bound + reset_cycles + margin_cycles;
	localparam int ack_limit = 64;
	localparam int stall_cycles = 40;
	localparam int backlog_limit = 12;

	logic clk;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [mode_pkg::wb_adr_w-1:0] wb_adr;
	logic [mode_pkg::wb_data_w-1:0] wb_dat_w;
	logic [mode_pkg::wb_data_w-1:0] wb_dat_r;
	logic wb_ack;

	int tb_errors = 0;
	int sets_written = 0;
	int results_read = 0;
	int mismatch_count;
	int orphan_count;
	int results_seen;
	int pending_sets;

	tb_clock #(.period(clk_period)) clk_gen (.clk(clk));

	mode_max_top mode_max_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack)
	);

	mode_checker mode_checker_inst (
		.clk(clk),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.mismatch_count(mismatch_count),
		.orphan_count(orphan_count),
		.results_seen(results_seen),
		.pending_sets(pending_sets)
	);

	// ========================================
	// Bus tasks
	// ========================================

	// Drives one Wishbone access on the falling edge and holds it until ack or time out.
	task automatic bus_access(input logic we, input logic [mode_pkg::wb_adr_w-1:0] adr,
			input logic [mode_pkg::wb_data_w-1:0] wdata, input int max_cycles,
			output logic [mode_pkg::wb_data_w-1:0] rdata, output bit acked);
		int waited;
		waited = 0;
		acked = 1'b0;
		rdata = '0;
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		while (!acked && waited < max_cycles) begin
			@(negedge clk);
			waited++;
			if (wb_ack) acked = 1'b1;
		end
		if (acked) rdata = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic check_acked(input bit acked, input string what);
		if (!acked) begin
			tb_errors++;
			$display("Time %0t: %s was not acknowledged within %0d cycles",
				$time, what, ack_limit);
		end
	endtask

	task automatic write_set(input mode_pkg::sample_set_t set);
		logic [mode_pkg::wb_data_w-1:0] rdata;
		bit acked;
		bus_access(1'b1, mode_pkg::adr_samples, 32'(set), ack_limit, rdata, acked);
		check_acked(acked, "Sample set write");
		if (acked) sets_written++;
	endtask

	task automatic read_result(output logic [mode_pkg::wb_data_w-1:0] word);
		bit acked;
		bus_access(1'b0, mode_pkg::adr_result, '0, ack_limit, word, acked);
		check_acked(acked, "Result read");
		if (acked && word[mode_pkg::rd_valid_bit]) results_read++;
	endtask

	task automatic drain_results();
		logic [mode_pkg::wb_data_w-1:0] word;
		int tries;
		tries = 0;
		while (results_read < sets_written && tries < 4 * ack_limit) begin
			read_result(word);
			tries++;
		end
		if (results_read < sets_written) begin
			tb_errors++;
			$display("Time %0t: only %0d of %0d results came back", $time,
				results_read, sets_written);
		end
	endtask

	// ========================================
	// Stimulus
	// ========================================

	function automatic mode_pkg::sample_set_t make_set(input logic [3:0] a, input logic [3:0] b,
			input logic [3:0] c, input logic [3:0] d, input logic [3:0] e);
		mode_pkg::sample_set_t set;
		set.s0 = a;
		set.s1 = b;
		set.s2 = c;
		set.s3 = d;
		set.s4 = e;
		return set;
	endfunction

	// A narrow span around a random base makes repeats common.
	function automatic mode_pkg::sample_set_t random_set();
		int span;
		logic [3:0] base;
		case ($urandom % 3)
			0: span = 16;
			1: span = 4;
			default: span = 2;
		endcase
		base = 4'($urandom % 16);
		return make_set(base + 4'($urandom % span), base + 4'($urandom % span),
			base + 4'($urandom % span), base + 4'($urandom % span),
			base + 4'($urandom % span));
	endfunction

	initial begin
		logic [mode_pkg::wb_data_w-1:0] word;
		mode_pkg::sample_set_t held;
		bit acked;
		int total;
		void'($urandom(32'haaad_ba73));
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (reset_cycles) @(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);

		// Empty result FIFO and unmapped addresses.
		read_result(word);
		bus_access(1'b0, 4'd7, '0, ack_limit, word, acked);
		check_acked(acked, "Unmapped read");
		bus_access(1'b1, 4'd9, 32'hffff_ffff, ack_limit, word, acked);
		check_acked(acked, "Unmapped write");

		write_set(make_set(4'd1, 4'd9, 4'd3, 4'd14, 4'd7));
		write_set(make_set(4'd0, 4'd1, 4'd2, 4'd3, 4'd4));
		write_set(make_set(4'd5, 4'd5, 4'd2, 4'd2, 4'd9)); // Two pairs.
		write_set(make_set(4'd3, 4'd8, 4'd8, 4'd1, 4'd0));
		write_set(make_set(4'd15, 4'd7, 4'd15, 4'd7, 4'd6));
		write_set(make_set(4'd6, 4'd6, 4'd6, 4'd15, 4'd2));
		write_set(make_set(4'd4, 4'd11, 4'd4, 4'd4, 4'd4));
		write_set(make_set(4'd10, 4'd10, 4'd10, 4'd10, 4'd10));
		write_set(make_set(4'd15, 4'd0, 4'd15, 4'd0, 4'd0)); // Triple beats a larger pair.
		write_set(make_set(4'd12, 4'd13, 4'd14, 4'd15, 4'd11));
		drain_results();

		for (int i = 0; i < random_sets; i++) begin
			if (sets_written - results_read >= backlog_limit) drain_results();
			write_set(random_set());
			if ($urandom % 4 != 0) read_result(word);
		end
		drain_results();

		// ========================================
		// Back-pressure with all buffers full
		// ========================================

		for (int i = 0; i < fill_sets - 1; i++) begin
			write_set(random_set());
		end
		held = random_set();
		bus_access(1'b1, mode_pkg::adr_samples, 32'(held), stall_cycles, word, acked);
		if (acked) begin
			sets_written++;
			tb_errors++;
			$display("Time %0t: a write was accepted with every buffer full", $time);
		end else begin
			read_result(word);
			write_set(held);
		end
		drain_results();
		read_result(word);

		repeat (4) @(negedge clk);
		total = tb_errors + mismatch_count + orphan_count + pending_sets;
		$display("Errors: %0d mismatches, %0d orphans, %0d unanswered, %0d bus (%0d checked)",
			mismatch_count, orphan_count, pending_sets, tb_errors, results_seen);
		if (total == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== verilog.f ====
verilog/mode_pkg.sv
verilog/stream_fifo.sv
verilog/host_port.sv
verilog/mode_engine.sv
verilog/mode_max_top.sv
tb/tb_clock.sv
tb/mode_checker.sv
tb/mode_max_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= mode_max_tb
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The exit status follows the pass line in the simulation output.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
